//--- design/core_pkg.sv
package core_pkg;

  // datapath and memory sizes.
  localparam int XLEN      = 32;
  localparam int RADDR_W   = 4;
  localparam int RAM_AW    = 6;
  localparam int MUL_STEPS = 8;
  localparam int MUL_BITS  = XLEN / MUL_STEPS;
  localparam int MUL_CNT_W = $clog2(MUL_STEPS);

  localparam logic [RADDR_W-1:0] PC_REG = 4'd15;

  // instruction class, bits 27:25.
  localparam logic [2:0] CLASS_DP  = 3'b000;
  localparam logic [2:0] CLASS_DPI = 3'b001;
  localparam logic [2:0] CLASS_MEM = 3'b010;
  localparam logic [2:0] CLASS_BR  = 3'b101;

  // alu opcodes.
  localparam logic [3:0] OP_AND = 4'b0000;
  localparam logic [3:0] OP_EOR = 4'b0001;
  localparam logic [3:0] OP_SUB = 4'b0010;
  localparam logic [3:0] OP_RSB = 4'b0011;
  localparam logic [3:0] OP_ADD = 4'b0100;
  localparam logic [3:0] OP_ORR = 4'b1100;
  localparam logic [3:0] OP_MOV = 4'b1101;
  localparam logic [3:0] OP_BIC = 4'b1110;
  localparam logic [3:0] OP_MVN = 4'b1111;

  // multiply marker in bits 7:4 of a class 000 word.
  localparam logic [3:0] MUL_TAG = 4'b1001;

  // multiply sequencer states.
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_BUSY = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  typedef struct packed {
    logic [3:0]  cond;
    logic [2:0]  cls;
    logic [3:0]  opcode;
    logic        s;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] op2;
  } dp_view_t;

  typedef struct packed {
    logic [3:0]  cond;
    logic [2:0]  cls;
    logic        p;
    logic        u;
    logic        b;
    logic        w;
    logic        l;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] off12;
  } mem_view_t;

  typedef union packed {
    dp_view_t  dp;
    mem_view_t mem;
  } instr_u;

endpackage

//--- design/register_file.sv
module register_file import core_pkg::*; (
  input  logic               clk_i,
  input  logic [RADDR_W-1:0] r1_addr_i,
  input  logic [RADDR_W-1:0] r2_addr_i,
  input  logic               wr_en_i,
  input  logic [RADDR_W-1:0] wr_addr_i,
  input  logic [XLEN-1:0]    data_i,
  input  logic [XLEN-1:0]    pc_i,
  output logic [XLEN-1:0]    r1_o,
  output logic [XLEN-1:0]    r2_o
);

  logic [XLEN-1:0] regs [2**RADDR_W];

  // r15 is never stored, it always reads as pc+8.
  always_ff @(posedge clk_i) begin
    if (wr_en_i && wr_addr_i != PC_REG) begin
      regs[wr_addr_i] <= data_i;
    end
  end

  function automatic logic [XLEN-1:0] read_port(input logic [RADDR_W-1:0] addr);
    if (addr == PC_REG) begin
      return pc_i + 32'd8;
    end else if (wr_en_i && wr_addr_i == addr) begin
      return data_i;
    end
    return regs[addr];
  endfunction

  assign r1_o = read_port(r1_addr_i);
  assign r2_o = read_port(r2_addr_i);

endmodule

//--- design/fetch_stage.sv
module fetch_stage import core_pkg::*; (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            stall_i,
  input  logic            branch_taken_i,
  input  logic [XLEN-1:0] branch_target_i,
  output logic [XLEN-1:0] pc_o,
  output logic            valid_o
);

  logic [XLEN-1:0] pc_q;
  logic            valid_q;

  // the slot after reset or a redirect is a bubble, so pc waits one cycle.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q    <= '0;
      valid_q <= 1'b0;
    end else if (branch_taken_i) begin
      pc_q    <= branch_target_i;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
      if (valid_q && !stall_i) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  assign pc_o    = pc_q;
  assign valid_o = valid_q;

endmodule

//--- design/decode_reg.sv
module decode_reg import core_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [XLEN-1:0]    pc_i,
  input  logic [XLEN-1:0]    inst_i,
  input  logic               valid_i,
  input  logic               flush_i,
  input  logic [XLEN-1:0]    wb_data_i,
  input  logic [RADDR_W-1:0] wb_addr_i,
  input  logic               wb_en_i,
  input  logic               stall_i,
  output logic               valid_o,
  output logic [XLEN-1:0]    r1_o,
  output logic [XLEN-1:0]    r2_o,
  output logic [XLEN-1:0]    inst_o,
  output logic [XLEN-1:0]    pc_o,
  output logic [RADDR_W-1:0] r1_addr_o,
  output logic [RADDR_W-1:0] r2_addr_o,
  output logic [RADDR_W-1:0] rd_addr_o
);

  instr_u             iw;
  logic [RADDR_W-1:0] r1_addr;
  logic [RADDR_W-1:0] r2_addr;
  logic [XLEN-1:0]    r1_rd;
  logic [XLEN-1:0]    r2_rd;

  assign iw = inst_i;

  // stores need rd as data, everything else reads rm.
  assign r1_addr = (iw.dp.cls == CLASS_MEM) ? iw.dp.rd : iw.dp.op2[3:0];
  assign r2_addr = iw.dp.rn;

  register_file u_rf (
    .clk_i     (clk_i),
    .r1_addr_i (r1_addr),
    .r2_addr_i (r2_addr),
    .wr_en_i   (wb_en_i),
    .wr_addr_i (wb_addr_i),
    .data_i    (wb_data_i),
    .pc_i      (pc_i),
    .r1_o      (r1_rd),
    .r2_o      (r2_rd)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      inst_o    <= inst_i;
      pc_o      <= pc_i;
      r1_o      <= r1_rd;
      r2_o      <= r2_rd;
      r1_addr_o <= r1_addr;
      r2_addr_o <= r2_addr;
      rd_addr_o <= iw.dp.rd;
    end
  end

endmodule

//--- design/execute_stage.sv
module execute_stage import core_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               valid_i,
  input  logic [XLEN-1:0]    inst_i,
  input  logic [XLEN-1:0]    pc_i,
  input  logic [XLEN-1:0]    r1_i,
  input  logic [XLEN-1:0]    r2_i,
  input  logic [RADDR_W-1:0] r1_addr_i,
  input  logic [RADDR_W-1:0] r2_addr_i,
  input  logic [RADDR_W-1:0] rd_addr_i,
  input  logic               stall_i,
  input  logic               mul_done_i,
  input  logic [XLEN-1:0]    ram_rdata_i,
  output logic               branch_taken_o,
  output logic [XLEN-1:0]    branch_target_o,
  output logic               mul_start_o,
  output logic               ram_we_o,
  output logic [RAM_AW-1:0]  ram_addr_o,
  output logic [XLEN-1:0]    ram_wdata_o,
  output logic               wb_en_o,
  output logic [RADDR_W-1:0] wb_addr_o,
  output logic [XLEN-1:0]    wb_data_o
);

  instr_u          iw;
  logic [XLEN-1:0] fwd_r1;
  logic [XLEN-1:0] fwd_r2;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] imm_rot;
  logic [63:0]     imm_dbl;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] mem_addr;
  logic [23:0]     br_off;
  logic            is_dp;
  logic            is_mul;
  logic            is_mem;
  logic            is_load;
  logic            alu_ok;
  logic            mul_busy;
  logic [XLEN-1:0] mcand_q;
  logic [XLEN-1:0] mplier_q;
  logic [XLEN-1:0] acc_q;
  logic [XLEN-1:0] partial;
  logic            load_q;
  logic [XLEN-1:0] wb_data_q;

  assign iw = inst_i;

  // writeback result overrides a stale operand, r15 never comes from there.
  assign fwd_r1 = (wb_en_o && wb_addr_o == r1_addr_i && r1_addr_i != PC_REG) ? wb_data_o : r1_i;
  assign fwd_r2 = (wb_en_o && wb_addr_o == r2_addr_i && r2_addr_i != PC_REG) ? wb_data_o : r2_i;

  assign is_mul  = valid_i && iw.dp.cls == CLASS_DP && iw.dp.op2[7:4] == MUL_TAG;
  assign is_dp   = valid_i && !is_mul && (iw.dp.cls == CLASS_DP || iw.dp.cls == CLASS_DPI);
  assign is_mem  = valid_i && iw.mem.cls == CLASS_MEM;
  assign is_load = is_mem && iw.mem.l;

  // rotate right by twice the 4-bit field.
  assign imm_dbl = {2{24'd0, iw.dp.op2[7:0]}};
  assign imm_rot = imm_dbl[{iw.dp.op2[11:8], 1'b0} +: XLEN];
  assign op_b    = (iw.dp.cls == CLASS_DPI) ? imm_rot : fwd_r1;

  always_comb begin
    alu_ok = 1'b1;
    case (iw.dp.opcode)
      OP_AND:  alu_res = fwd_r2 & op_b;
      OP_EOR:  alu_res = fwd_r2 ^ op_b;
      OP_SUB:  alu_res = fwd_r2 - op_b;
      OP_RSB:  alu_res = op_b - fwd_r2;
      OP_ADD:  alu_res = fwd_r2 + op_b;
      OP_ORR:  alu_res = fwd_r2 | op_b;
      OP_MOV:  alu_res = op_b;
      OP_BIC:  alu_res = fwd_r2 & ~op_b;
      OP_MVN:  alu_res = ~op_b;
      default: begin
        alu_res = '0;
        alu_ok  = 1'b0;
      end
    endcase
  end

  assign br_off          = iw.mem[23:0];
  assign branch_taken_o  = valid_i && iw.dp.cls == CLASS_BR;
  assign branch_target_o = pc_i + 32'd8 + {{6{br_off[23]}}, br_off, 2'b00};

  assign mem_addr    = iw.mem.u ? fwd_r2 + {20'd0, iw.mem.off12} : fwd_r2 - {20'd0, iw.mem.off12};
  assign ram_we_o    = is_mem && !iw.mem.l;
  assign ram_addr_o  = mem_addr[RAM_AW+1:2];
  assign ram_wdata_o = fwd_r1;

  assign mul_start_o = is_mul && !mul_busy;

  always_ff @(posedge clk_i) begin
    if (reset_i || mul_done_i) begin
      mul_busy <= 1'b0;
    end else if (mul_start_o) begin
      mul_busy <= 1'b1;
    end
  end

  // one nibble of rm per stalled cycle.
  always_comb begin
    partial = '0;
    for (int k = 0; k < MUL_BITS; k++) begin
      if (mplier_q[k]) begin
        partial = partial + (mcand_q << k);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mul_start_o) begin
      mcand_q  <= fwd_r2;
      mplier_q <= fwd_r1;
      acc_q    <= '0;
    end else if (mul_busy && stall_i) begin
      acc_q    <= acc_q + partial;
      mcand_q  <= mcand_q << MUL_BITS;
      mplier_q <= mplier_q >> MUL_BITS;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_en_o <= 1'b0;
      load_q  <= 1'b0;
    end else if (mul_done_i || stall_i) begin
      wb_en_o <= mul_done_i;
      load_q  <= 1'b0;
    end else begin
      wb_en_o <= (is_dp && alu_ok) || is_load;
      load_q  <= is_load;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mul_done_i || !stall_i) begin
      wb_addr_o <= rd_addr_i;
      wb_data_q <= mul_done_i ? acc_q : alu_res;
    end
  end

  // load data arrives from the ram during the writeback cycle.
  assign wb_data_o = load_q ? ram_rdata_i : wb_data_q;

endmodule

//--- design/mul_timer.sv
module mul_timer import core_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic start_i,
  output logic last_o
);

  logic [MUL_CNT_W-1:0] count_q;
  logic                 running_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q   <= '0;
      running_q <= 1'b0;
    end else if (start_i) begin
      count_q   <= MUL_CNT_W'(MUL_STEPS - 1);
      running_q <= 1'b1;
    end else if (running_q) begin
      count_q   <= count_q - MUL_CNT_W'(1);
      running_q <= (count_q != '0);
    end
  end

  assign last_o = running_q && (count_q == '0);

endmodule

//--- design/pipe_ctrl.sv
module pipe_ctrl import core_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic mul_start_i,
  input  logic mul_last_i,
  output logic stall_o,
  output logic timer_start_o,
  output logic mul_done_o
);

  logic [1:0] state_q;
  logic [1:0] state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (mul_start_i) state_d = ST_BUSY;
      ST_BUSY: if (mul_last_i) state_d = ST_DONE;
      ST_DONE: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // stall starts in the same cycle the multiply enters execute.
  assign timer_start_o = (state_q == ST_IDLE) && mul_start_i;
  assign stall_o       = timer_start_o || (state_q == ST_BUSY);
  assign mul_done_o    = (state_q == ST_DONE);

endmodule

//--- design/data_ram.sv
module data_ram import core_pkg::*; (
  input  logic              clk_i,
  input  logic              we_i,
  input  logic [RAM_AW-1:0] addr_i,
  input  logic [XLEN-1:0]   wdata_i,
  output logic [XLEN-1:0]   rdata_o
);

  logic [XLEN-1:0] mem [2**RAM_AW];

  // the read returns the old word when the same address is written.
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
    rdata_o <= mem[addr_i];
  end

endmodule

//--- design/core_top.sv
module core_top import core_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [XLEN-1:0]    inst_i,
  output logic [XLEN-1:0]    pc_o,
  output logic               wb_en_o,
  output logic [RADDR_W-1:0] wb_addr_o,
  output logic [XLEN-1:0]    wb_data_o
);

  logic               fetch_valid;
  logic               stall;
  logic               branch_taken;
  logic [XLEN-1:0]    branch_target;
  logic               dec_valid;
  logic [XLEN-1:0]    dec_inst;
  logic [XLEN-1:0]    dec_pc;
  logic [XLEN-1:0]    dec_r1;
  logic [XLEN-1:0]    dec_r2;
  logic [RADDR_W-1:0] dec_r1_addr;
  logic [RADDR_W-1:0] dec_r2_addr;
  logic [RADDR_W-1:0] dec_rd_addr;
  logic               mul_start;
  logic               mul_last;
  logic               mul_done;
  logic               timer_start;
  logic               ram_we;
  logic [RAM_AW-1:0]  ram_addr;
  logic [XLEN-1:0]    ram_wdata;
  logic [XLEN-1:0]    ram_rdata;

  fetch_stage u_fetch (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .stall_i         (stall),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .pc_o            (pc_o),
    .valid_o         (fetch_valid)
  );

  decode_reg u_decode (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .pc_i      (pc_o),
    .inst_i    (inst_i),
    .valid_i   (fetch_valid),
    .flush_i   (branch_taken),
    .wb_data_i (wb_data_o),
    .wb_addr_i (wb_addr_o),
    .wb_en_i   (wb_en_o),
    .stall_i   (stall),
    .valid_o   (dec_valid),
    .r1_o      (dec_r1),
    .r2_o      (dec_r2),
    .inst_o    (dec_inst),
    .pc_o      (dec_pc),
    .r1_addr_o (dec_r1_addr),
    .r2_addr_o (dec_r2_addr),
    .rd_addr_o (dec_rd_addr)
  );

  execute_stage u_execute (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .valid_i         (dec_valid),
    .inst_i          (dec_inst),
    .pc_i            (dec_pc),
    .r1_i            (dec_r1),
    .r2_i            (dec_r2),
    .r1_addr_i       (dec_r1_addr),
    .r2_addr_i       (dec_r2_addr),
    .rd_addr_i       (dec_rd_addr),
    .stall_i         (stall),
    .mul_done_i      (mul_done),
    .ram_rdata_i     (ram_rdata),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .mul_start_o     (mul_start),
    .ram_we_o        (ram_we),
    .ram_addr_o      (ram_addr),
    .ram_wdata_o     (ram_wdata),
    .wb_en_o         (wb_en_o),
    .wb_addr_o       (wb_addr_o),
    .wb_data_o       (wb_data_o)
  );

  pipe_ctrl u_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mul_start_i   (mul_start),
    .mul_last_i    (mul_last),
    .stall_o       (stall),
    .timer_start_o (timer_start),
    .mul_done_o    (mul_done)
  );

  mul_timer u_timer (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (timer_start),
    .last_o  (mul_last)
  );

  data_ram u_ram (
    .clk_i   (clk_i),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

endmodule

//--- verif/tb_clock.sv
module tb_clock (
  input  logic restart_i,
  output logic clk_o,
  output logic reset_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned hold_q = 3;
  logic        req;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset covers three rising edges, at power up and after each restart request.
  always @(posedge clk_o) begin
    req = restart_i;
    #1;
    if (req) begin
      hold_q = 3;
    end else if (hold_q != 0) begin
      hold_q = hold_q - 1;
    end
  end

  assign reset_o = (hold_q != 0);

endmodule

//--- verif/core_tb.sv
module core_tb import core_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS    = 6;
  localparam int IMEM_WORDS   = 256;
  localparam int DRAIN_CYCLES = 10;
  localparam int RUN_LIMIT    = NUM_TESTS * (12 * IMEM_WORDS + 50 + DRAIN_CYCLES + 10);

  localparam logic [3:0] ALU_OPS [9] = '{OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD,
                                         OP_ORR, OP_MOV, OP_BIC, OP_MVN};

  logic               clk_i;
  logic               reset_i;
  logic               restart;
  logic [XLEN-1:0]    inst_i;
  logic [XLEN-1:0]    pc_o;
  logic               wb_en_o;
  logic [RADDR_W-1:0] wb_addr_o;
  logic [XLEN-1:0]    wb_data_o;

  logic [XLEN-1:0]    imem [IMEM_WORDS];
  int                 n_instr;
  logic [XLEN-1:0]    mregs [16];
  logic [XLEN-1:0]    mmem [64];
  bit                 mwritten [64];
  logic [RADDR_W-1:0] exp_addr_q [$];
  logic [XLEN-1:0]    exp_data_q [$];
  logic [31:0]        lcg_state = 32'h7cca_4c2a;
  bit                 checking;
  int                 errors;
  int                 n_run;
  int                 n_pass;
  int                 n_fail;
  int                 cycle_count;
  string              test_name;

  tb_clock u_clock (
    .restart_i (restart),
    .clk_o     (clk_i),
    .reset_o   (reset_i)
  );

  core_top core_top_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .inst_i    (inst_i),
    .pc_o      (pc_o),
    .wb_en_o   (wb_en_o),
    .wb_addr_o (wb_addr_o),
    .wb_data_o (wb_data_o)
  );

  // instruction memory answers the fetch address in the same cycle.
  assign inst_i = imem[pc_o[9:2]];

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    logic [31:0] r;
    r = lcg_next();
    return 32'(r[31:8]) % n;
  endfunction

  function automatic logic [31:0] encode_dp(input logic [3:0] op, input logic [3:0] rd,
                                            input logic [3:0] rn, input logic [3:0] rm);
    return {4'hE, CLASS_DP, op, 1'b0, rn, rd, 8'h00, rm};
  endfunction

  function automatic logic [31:0] encode_dpi(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [3:0] rn, input logic [3:0] rot,
                                             input logic [7:0] imm);
    return {4'hE, CLASS_DPI, op, 1'b0, rn, rd, rot, imm};
  endfunction

  function automatic logic [31:0] encode_mem(input logic ld, input logic up, input logic [3:0] rn,
                                             input logic [3:0] rd, input logic [11:0] off);
    return {4'hE, CLASS_MEM, 1'b1, up, 1'b0, 1'b0, ld, rn, rd, off};
  endfunction

  function automatic logic [31:0] encode_mul(input logic [3:0] rd, input logic [3:0] rn,
                                             input logic [3:0] rm);
    return {4'hE, CLASS_DP, 4'b0000, 1'b0, rn, rd, 4'h0, MUL_TAG, rm};
  endfunction

  function automatic logic [31:0] encode_br(input logic [23:0] off);
    return {4'hE, CLASS_BR, 1'b0, off};
  endfunction

  function automatic logic [31:0] reg_val(input logic [3:0] r, input logic [31:0] pc);
    return (r == 4'd15) ? pc + 32'd8 : mregs[r];
  endfunction

  function automatic void model_write(input logic [3:0] rd, input logic [31:0] v);
    mregs[rd] = v;
    exp_addr_q.push_back(rd);
    exp_data_q.push_back(v);
  endfunction

  // architectural effect of one instruction, taken from the instruction set rules.
  function automatic void model_exec(input logic [31:0] w, input logic [31:0] pc);
    logic [2:0]  cls;
    logic [3:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    int          sh;
    cls = w[27:25];
    rd  = w[15:12];
    a   = reg_val(w[19:16], pc);
    if (cls == CLASS_DP && w[7:4] == MUL_TAG) begin
      model_write(rd, a * reg_val(w[3:0], pc));
    end else if (cls == CLASS_DP || cls == CLASS_DPI) begin
      if (cls == CLASS_DPI) begin
        imm = {24'd0, w[7:0]};
        sh  = 2 * int'(w[11:8]);
        b   = (sh == 0) ? imm : ((imm >> sh) | (imm << (32 - sh)));
      end else begin
        b = reg_val(w[3:0], pc);
      end
      case (w[24:21])
        OP_AND:  model_write(rd, a & b);
        OP_EOR:  model_write(rd, a ^ b);
        OP_SUB:  model_write(rd, a - b);
        OP_RSB:  model_write(rd, b - a);
        OP_ADD:  model_write(rd, a + b);
        OP_ORR:  model_write(rd, a | b);
        OP_MOV:  model_write(rd, b);
        OP_BIC:  model_write(rd, a & ~b);
        OP_MVN:  model_write(rd, ~b);
        default: ;
      endcase
    end else if (cls == CLASS_MEM) begin
      addr = w[23] ? a + {20'd0, w[11:0]} : a - {20'd0, w[11:0]};
      if (w[20]) begin
        model_write(rd, mmem[addr[7:2]]);
      end else begin
        mmem[addr[7:2]]     = reg_val(rd, pc);
        mwritten[addr[7:2]] = 1'b1;
      end
    end
  endfunction

  function automatic void emit(input logic [31:0] w);
    imem[n_instr] = w;
    n_instr++;
  endfunction

  function automatic void emit_exec(input logic [31:0] w);
    model_exec(w, 32'(n_instr * 4));
    emit(w);
  endfunction

  // unused words branch back to address 0.
  function automatic void start_program();
    exp_addr_q.delete();
    exp_data_q.delete();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = encode_br(24'(-(i + 2)));
    end
    for (int i = 0; i < 64; i++) begin
      mwritten[i] = 1'b0;
    end
    n_instr = 0;
    for (int r = 0; r < 15; r++) begin
      emit_exec(encode_dpi(OP_MOV, 4'(r), 4'd0, 4'(pick(16)), 8'(pick(256))));
    end
  endfunction

  function automatic void gen_alu();
    logic [3:0] op;
    op = ALU_OPS[pick(9)];
    if (pick(2) == 0) begin
      emit_exec(encode_dpi(op, 4'(pick(15)), 4'(pick(16)), 4'(pick(16)), 8'(pick(256))));
    end else begin
      emit_exec(encode_dp(op, 4'(pick(15)), 4'(pick(16)), 4'(pick(16))));
    end
  endfunction

  // a producer, then d-1 unrelated writes, then a consumer of the producer.
  function automatic void gen_dep(input int d);
    logic [3:0] src;
    logic [3:0] other;
    src = 4'(pick(15));
    emit_exec(encode_dp(ALU_OPS[pick(9)], src, 4'(pick(16)), 4'(pick(16))));
    for (int i = 1; i < d; i++) begin
      other = 4'((int'(src) + 1 + int'(pick(14))) % 15);
      emit_exec(encode_dpi(ALU_OPS[pick(9)], other, 4'(pick(15)), 4'(pick(16)), 8'(pick(256))));
    end
    other = (pick(2) == 0) ? src : 4'(pick(15));
    emit_exec(encode_dp(ALU_OPS[pick(9)], 4'(pick(15)), src, other));
  endfunction

  // offset is chosen so that address bits 7:2 land on the wanted word.
  function automatic void gen_mem();
    logic [3:0]  rn;
    logic [31:0] v;
    logic        up;
    logic        ld;
    logic [5:0]  idx;
    logic [11:0] off;
    int          start;
    rn    = 4'(pick(15));
    v     = mregs[rn];
    up    = 1'(pick(2));
    idx   = 6'(pick(64));
    ld    = 1'b0;
    start = int'(idx);
    if (pick(2) == 0) begin
      for (int i = 0; i < 64; i++) begin
        if (!ld && mwritten[6'(start + i)]) begin
          idx = 6'(start + i);
          ld  = 1'b1;
        end
      end
    end
    if (up) begin
      off = 12'(({26'd0, idx} * 32'd4 - v) & 32'hFF);
    end else begin
      off = 12'((v - {26'd0, idx} * 32'd4) & 32'hFF);
    end
    emit_exec(encode_mem(ld, up, rn, 4'(pick(15)), off));
  endfunction

  // skipped words would write back if they ever retired.
  function automatic void gen_branch();
    int unsigned k;
    k = pick(4);
    emit(encode_br(24'(k)));
    for (int unsigned i = 0; i <= k; i++) begin
      emit(encode_dpi(OP_MOV, 4'(pick(15)), 4'd0, 4'd0, 8'(pick(256))));
    end
  endfunction

  function automatic void gen_mul();
    logic [3:0] rn;
    logic [3:0] rm;
    rn = 4'(pick(15));
    rm = 4'(pick(15));
    case (pick(4))
      0: emit_exec(encode_dpi(OP_MOV, rn, 4'd0, 4'd0, 8'd0));
      1: emit_exec(encode_dpi(OP_MVN, rm, 4'd0, 4'd0, 8'd0));
      2: begin
        emit_exec(encode_dpi(OP_MVN, rn, 4'd0, 4'd0, 8'd0));
        emit_exec(encode_dpi(OP_MVN, rm, 4'd0, 4'd0, 8'd0));
      end
      default: ;
    endcase
    emit_exec(encode_mul(4'(pick(15)), rn, rm));
  endfunction

  task automatic check_reset_outputs();
    assert (wb_en_o == 1'b0) else begin
      $display("ERR %0t wb_en_o expected 0 got %0b", $time, wb_en_o);
      errors++;
    end
    assert (pc_o == '0) else begin
      $display("ERR %0t pc_o expected 00000000 got %h", $time, pc_o);
      errors++;
    end
  endtask

  task automatic run_program(input string name);
    int budget;
    int cycles;
    int errs_before;
    int expected;
    emit(encode_br(24'hFFFFFE));
    test_name   = name;
    errs_before = errors;
    expected    = exp_addr_q.size();
    budget      = 12 * n_instr + 50;
    restart     = 1'b1;
    @(posedge clk_i);
    #1 restart = 1'b0;
    @(posedge clk_i);
    do begin
      @(negedge clk_i);
      check_reset_outputs();
    end while (reset_i);
    checking = 1'b1;
    cycles   = 0;
    while (exp_addr_q.size() != 0 && cycles < budget) begin
      @(posedge clk_i);
      cycles++;
    end
    repeat (DRAIN_CYCLES) @(posedge clk_i);
    #1;
    checking = 1'b0;
    assert (exp_addr_q.size() == 0) else begin
      $display("%s: %0d expected writebacks never arrived within %0d cycles",
               name, exp_addr_q.size(), budget);
      errors++;
    end
    n_run++;
    if (errors == errs_before) begin
      n_pass++;
      $display("test %-12s PASS  %0d writebacks", name, expected);
    end else begin
      n_fail++;
      $display("test %-12s FAIL  %0d errors", name, errors - errs_before);
    end
  endtask

  always @(negedge clk_i) begin
    if (checking && wb_en_o) begin
      assert (exp_addr_q.size() != 0) else begin
        $display("%0t %s: writeback to r%0d arrived with no writeback left to expect",
                 $time, test_name, wb_addr_o);
        errors++;
      end
      if (exp_addr_q.size() != 0) begin
        assert (wb_addr_o == exp_addr_q[0]) else begin
          $display("ERR %0t wb_addr_o expected %0d got %0d", $time, exp_addr_q[0], wb_addr_o);
          errors++;
        end
        assert (wb_data_o == exp_data_q[0]) else begin
          $display("ERR %0t wb_data_o expected %h got %h", $time, exp_data_q[0], wb_data_o);
          errors++;
        end
        void'(exp_addr_q.pop_front());
        void'(exp_data_q.pop_front());
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > RUN_LIMIT) begin
      $display("run stopped after %0d cycles without finishing", RUN_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    restart     = 1'b0;
    checking    = 1'b0;
    errors      = 0;
    n_run       = 0;
    n_pass      = 0;
    n_fail      = 0;
    cycle_count = 0;
    start_program();
    run_program("reset_state");
    start_program();
    repeat (80) gen_alu();
    run_program("alu_random");
    start_program();
    for (int i = 0; i < 30; i++) begin
      gen_dep(i % 3 + 1);
    end
    run_program("forwarding");
    start_program();
    repeat (40) begin
      gen_mem();
      if (pick(3) == 0) begin
        gen_alu();
      end
    end
    run_program("store_load");
    start_program();
    repeat (20) begin
      gen_alu();
      gen_branch();
    end
    run_program("branch");
    start_program();
    repeat (12) begin
      gen_mul();
      gen_alu();
    end
    run_program("multiply");
    $display("summary: %0d run, %0d pass, %0d fail, %0d errors", n_run, n_pass, n_fail, errors);
    if (n_fail == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- sim.f
design/core_pkg.sv
design/register_file.sv
design/fetch_stage.sv
design/decode_reg.sv
design/execute_stage.sv
design/mul_timer.sv
design/pipe_ctrl.sv
design/data_ram.sv
design/core_top.sv
verif/tb_clock.sv
verif/core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module core_tb -f sim.f --Mdir obj_dir -o core_sim
./obj_dir/core_sim | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"
